// File: hw/branchPkg.sv
// Shared definitions for the predicting fetch front end
// Word widths, RISC-V opcode fields, reset PC and predictor table sizes
package branchPkg;

    // Predictor geometry
    localparam int BtbEntries = 32;
    localparam int BtbIdxBits = 5;
    localparam int GhrBits    = 5;
    // Tag covers PC bits 31 down to 7
    localparam int BtbTagBits = 25;

    // Meaningful widths
    typedef logic [31:0]           xlenT;
    typedef logic [31:0]           instrT;
    typedef logic [6:0]            opcodeT;
    typedef logic [2:0]            funct3T;
    typedef logic [BtbIdxBits-1:0] btbIdxT;
    typedef logic [GhrBits-1:0]    ghrT;
    typedef logic [1:0]            counterT;

    localparam xlenT ResetPc = 32'h0000_0000;

    // Opcodes handled by the front end
    localparam opcodeT OpBranch = 7'h63;
    localparam opcodeT OpJal    = 7'h6F;

    // Conditional branch kinds
    localparam funct3T Funct3Beq = 3'd0;
    localparam funct3T Funct3Bne = 3'd1;

    // Weakly not taken
    localparam counterT CounterInit = 2'd1;

endpackage

// File: hw/branchIfs.sv
// Interfaces between the front end stages
// Fetch bundle towards decode and resolve feedback towards fetch
`timescale 1ns/1ps

interface fetchDecodeIf;
    import branchPkg::*;

    instrT instr;
    xlenT  pc;
    xlenT  srcA;
    xlenT  srcB;
    logic  predTaken;
    // Counter index captured at fetch time
    ghrT   phtIdx;

    modport source (output instr, pc, srcA, srcB, predTaken, phtIdx);
    modport sink   (input  instr, pc, srcA, srcB, predTaken, phtIdx);
endinterface

interface resolveIf;
    import branchPkg::*;

    logic                  mispredict;
    xlenT                  redirectPc;
    logic                  btbWe;
    btbIdxT                btbIdx;
    logic [BtbTagBits-1:0] btbTag;
    xlenT                  btbTarget;
    logic                  phtWe;
    ghrT                   phtIdx;
    logic                  actualTaken;

    modport source (output mispredict, redirectPc, btbWe, btbIdx, btbTag, btbTarget,
                    phtWe, phtIdx, actualTaken);
    modport sink   (input  mispredict, redirectPc, btbWe, btbIdx, btbTag, btbTarget,
                    phtWe, phtIdx, actualTaken);
endinterface

// File: hw/branchTargetBuffer.sv
// Branch target buffer
// Direct mapped valid/tag/target table, read at fetch and written from execute
`timescale 1ns/1ps

module branchTargetBuffer (
    input  logic                             clk,
    input  logic                             reset,
    input  branchPkg::xlenT                  pc_i,
    output logic                             hit_o,
    output branchPkg::xlenT                  target_o,
    input  logic                             we_i,
    input  branchPkg::btbIdxT                wrIdx_i,
    input  logic [branchPkg::BtbTagBits-1:0] wrTag_i,
    input  branchPkg::xlenT                  wrTarget_i
);
    import branchPkg::*;

    logic [BtbEntries-1:0] valid;
    logic [BtbTagBits-1:0] tags    [BtbEntries];
    xlenT                  targets [BtbEntries];

    btbIdxT                rdIdx;
    logic [BtbTagBits-1:0] rdTag;

    // Word aligned index, tag from the remaining upper bits
    assign rdIdx = pc_i[BtbIdxBits+1:2];
    assign rdTag = pc_i[31:BtbIdxBits+2];

    assign hit_o    = valid[rdIdx] && (tags[rdIdx] == rdTag);
    assign target_o = targets[rdIdx];

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
        end else if (we_i) begin
            valid[wrIdx_i] <= 1'b1;
        end
    end

    // Tag and target storage
    always_ff @(posedge clk) begin
        if (we_i) begin
            tags[wrIdx_i]    <= wrTag_i;
            targets[wrIdx_i] <= wrTarget_i;
        end
    end

endmodule

// File: hw/gsharePredictor.sv
// Gshare direction predictor
// Global history XOR PC indexes a table of 2-bit saturating counters
`timescale 1ns/1ps

module gsharePredictor (
    input  logic             clk,
    input  logic             reset,
    input  branchPkg::xlenT  pc_i,
    input  logic             fetchIsBranch_i,
    input  logic             mispredict_i,
    input  logic             updWe_i,
    input  branchPkg::ghrT   updIdx_i,
    input  logic             updTaken_i,
    output logic             predTaken_o,
    output branchPkg::ghrT   idx_o
);
    import branchPkg::*;

    ghrT     ghr;
    counterT pht [2**GhrBits];

    // Index formed from the word address bits and the history
    assign idx_o       = pc_i[GhrBits+1:2] ^ ghr;
    assign predTaken_o = pht[idx_o][1];

    // History register, clear on mispredict wins over the shift
    always_ff @(posedge clk) begin
        if (reset) begin
            ghr <= '0;
        end else if (mispredict_i) begin
            ghr <= '0;
        end else if (fetchIsBranch_i) begin
            // Shift in the counter's direction for this fetch
            ghr <= {ghr[GhrBits-2:0], predTaken_o};
        end
    end

    // Counter update at the index captured in fetch
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**GhrBits; i++) begin
                pht[i] <= CounterInit;
            end
        end else if (updWe_i) begin
            if (updTaken_i) begin
                if (pht[updIdx_i] != 2'd3) begin
                    pht[updIdx_i] <= pht[updIdx_i] + 2'd1;
                end
            end else begin
                if (pht[updIdx_i] != 2'd0) begin
                    pht[updIdx_i] <= pht[updIdx_i] - 2'd1;
                end
            end
        end
    end

endmodule

// File: hw/fetchUnit.sv
// Fetch stage
// Holds the PC, predicts the next fetch address and bundles the instruction for decode
`timescale 1ns/1ps

module fetchUnit (
    input  logic              clk,
    input  logic              reset,
    input  branchPkg::instrT  instrF_i,
    input  branchPkg::xlenT   srcAF_i,
    input  branchPkg::xlenT   srcBF_i,
    output branchPkg::xlenT   pcF_o,
    fetchDecodeIf.source      fd,
    resolveIf.sink            rs
);
    import branchPkg::*;

    opcodeT opF;
    logic   isBranchF;
    logic   isJalF;
    logic   btbHit;
    xlenT   btbTarget;
    logic   ctrTaken;
    ghrT    phtIdxF;
    logic   predTakenF;
    xlenT   pcPlus4F;
    xlenT   pcNext;

    assign opF       = instrF_i[6:0];
    assign isBranchF = (opF == OpBranch);
    assign isJalF    = (opF == OpJal);

    branchTargetBuffer u_btb (
        .clk        (clk),
        .reset      (reset),
        .pc_i       (pcF_o),
        .hit_o      (btbHit),
        .target_o   (btbTarget),
        .we_i       (rs.btbWe),
        .wrIdx_i    (rs.btbIdx),
        .wrTag_i    (rs.btbTag),
        .wrTarget_i (rs.btbTarget)
    );

    gsharePredictor u_gshare (
        .clk             (clk),
        .reset           (reset),
        .pc_i            (pcF_o),
        .fetchIsBranch_i (isBranchF),
        .mispredict_i    (rs.mispredict),
        .updWe_i         (rs.phtWe),
        .updIdx_i        (rs.phtIdx),
        .updTaken_i      (rs.actualTaken),
        .predTaken_o     (ctrTaken),
        .idx_o           (phtIdxF)
    );

    // Taken needs a target, jal always goes, branches follow the counter
    assign predTakenF = btbHit && (isJalF || (isBranchF && ctrTaken));

    assign pcPlus4F = pcF_o + 32'd4;

    // Redirect from execute has priority over the prediction
    always_comb begin
        if (rs.mispredict) begin
            pcNext = rs.redirectPc;
        end else if (predTakenF) begin
            pcNext = btbTarget;
        end else begin
            pcNext = pcPlus4F;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pcF_o <= ResetPc;
        end else begin
            pcF_o <= pcNext;
        end
    end

    // Bundle for decode
    assign fd.instr     = instrF_i;
    assign fd.pc        = pcF_o;
    assign fd.srcA      = srcAF_i;
    assign fd.srcB      = srcBF_i;
    assign fd.predTaken = predTakenF;
    assign fd.phtIdx    = phtIdxF;

endmodule

// File: hw/decodeStage.sv
// Decode stage
// Registers the fetch bundle and builds the B or J immediate
`timescale 1ns/1ps

module decodeStage (
    input  logic              clk,
    input  logic              reset,
    input  logic              flush_i,
    fetchDecodeIf.sink        fd,
    output branchPkg::xlenT   pcD_o,
    output branchPkg::xlenT   immD_o,
    output branchPkg::opcodeT opD_o,
    output branchPkg::funct3T funct3D_o,
    output branchPkg::xlenT   srcAD_o,
    output branchPkg::xlenT   srcBD_o,
    output logic              predTakenD_o,
    output branchPkg::ghrT    phtIdxD_o
);
    import branchPkg::*;

    instrT instrD;

    // Control part of the register, bubble has opcode zero
    always_ff @(posedge clk) begin
        if (reset || flush_i) begin
            instrD       <= '0;
            predTakenD_o <= 1'b0;
            phtIdxD_o    <= '0;
        end else begin
            instrD       <= fd.instr;
            predTakenD_o <= fd.predTaken;
            phtIdxD_o    <= fd.phtIdx;
        end
    end

    // Payload, only meaningful alongside a valid opcode
    always_ff @(posedge clk) begin
        pcD_o   <= fd.pc;
        srcAD_o <= fd.srcA;
        srcBD_o <= fd.srcB;
    end

    assign opD_o     = instrD[6:0];
    assign funct3D_o = instrD[14:12];

    always_comb begin
        case (opD_o)
            OpBranch: begin
                immD_o = {{20{instrD[31]}}, instrD[7], instrD[30:25],
                          instrD[11:8], 1'b0};
            end
            OpJal: begin
                immD_o = {{12{instrD[31]}}, instrD[19:12], instrD[20],
                          instrD[30:21], 1'b0};
            end
            default: begin
                // Other opcodes never use the immediate here
                immD_o = '0;
            end
        endcase
    end

endmodule

// File: hw/branchResolver.sv
// Execute stage branch resolution
// Computes the real direction, flags mispredicts and drives predictor updates
`timescale 1ns/1ps

module branchResolver (
    input  logic              clk,
    input  logic              reset,
    input  branchPkg::xlenT   pcD_i,
    input  branchPkg::xlenT   immD_i,
    input  branchPkg::opcodeT opD_i,
    input  branchPkg::funct3T funct3D_i,
    input  branchPkg::xlenT   srcAD_i,
    input  branchPkg::xlenT   srcBD_i,
    input  logic              predTakenD_i,
    input  branchPkg::ghrT    phtIdxD_i,
    resolveIf.source          rs
);
    import branchPkg::*;

    xlenT   pcE;
    xlenT   immE;
    opcodeT opE;
    funct3T funct3E;
    xlenT   srcAE;
    xlenT   srcBE;
    logic   predTakenE;
    ghrT    phtIdxE;

    logic   isBranchE;
    logic   isJalE;
    logic   takenE;
    xlenT   targetE;

    // A mispredict turns the instruction behind it into a bubble too
    always_ff @(posedge clk) begin
        if (reset || rs.mispredict) begin
            opE        <= '0;
            funct3E    <= '0;
            predTakenE <= 1'b0;
            phtIdxE    <= '0;
        end else begin
            opE        <= opD_i;
            funct3E    <= funct3D_i;
            predTakenE <= predTakenD_i;
            phtIdxE    <= phtIdxD_i;
        end
    end

    always_ff @(posedge clk) begin
        pcE   <= pcD_i;
        immE  <= immD_i;
        srcAE <= srcAD_i;
        srcBE <= srcBD_i;
    end

    assign isBranchE = (opE == OpBranch);
    assign isJalE    = (opE == OpJal);
    assign targetE   = pcE + immE;

    always_comb begin
        takenE = 1'b0;
        if (isJalE) begin
            takenE = 1'b1;
        end else if (isBranchE) begin
            case (funct3E)
                Funct3Beq: takenE = (srcAE == srcBE);
                Funct3Bne: takenE = (srcAE != srcBE);
                default:   takenE = 1'b0;
            endcase
        end
    end

    assign rs.mispredict  = (isBranchE || isJalE) && (takenE != predTakenE);
    // Predicted taken went to the target, so repair to the fall through
    assign rs.redirectPc  = predTakenE ? (pcE + 32'd4) : targetE;

    assign rs.btbWe       = (isBranchE || isJalE) && takenE;
    assign rs.btbIdx      = pcE[BtbIdxBits+1:2];
    assign rs.btbTag      = pcE[31:BtbIdxBits+2];
    assign rs.btbTarget   = targetE;

    assign rs.phtWe       = isBranchE;
    assign rs.phtIdx      = phtIdxE;
    assign rs.actualTaken = takenE;

endmodule

// File: hw/predictorCore.sv
// Predicting front end top level
// Fetch, decode and branch resolve stages joined through their interfaces
`timescale 1ns/1ps

module predictorCore (
    input  logic             clk,
    input  logic             reset,
    input  branchPkg::instrT instrF_i,
    input  branchPkg::xlenT  srcAF_i,
    input  branchPkg::xlenT  srcBF_i,
    output branchPkg::xlenT  pcF_o,
    output logic             mispredict_o
);
    import branchPkg::*;

    fetchDecodeIf fdIf ();
    resolveIf     rsIf ();

    // Decoded record heading into execute
    xlenT   pcD;
    xlenT   immD;
    opcodeT opD;
    funct3T funct3D;
    xlenT   srcAD;
    xlenT   srcBD;
    logic   predTakenD;
    ghrT    phtIdxD;

    fetchUnit u_fetch (
        .clk      (clk),
        .reset    (reset),
        .instrF_i (instrF_i),
        .srcAF_i  (srcAF_i),
        .srcBF_i  (srcBF_i),
        .pcF_o    (pcF_o),
        .fd       (fdIf.source),
        .rs       (rsIf.sink)
    );

    decodeStage u_decode (
        .clk          (clk),
        .reset        (reset),
        .flush_i      (rsIf.mispredict),
        .fd           (fdIf.sink),
        .pcD_o        (pcD),
        .immD_o       (immD),
        .opD_o        (opD),
        .funct3D_o    (funct3D),
        .srcAD_o      (srcAD),
        .srcBD_o      (srcBD),
        .predTakenD_o (predTakenD),
        .phtIdxD_o    (phtIdxD)
    );

    branchResolver u_resolve (
        .clk          (clk),
        .reset        (reset),
        .pcD_i        (pcD),
        .immD_i       (immD),
        .opD_i        (opD),
        .funct3D_i    (funct3D),
        .srcAD_i      (srcAD),
        .srcBD_i      (srcBD),
        .predTakenD_i (predTakenD),
        .phtIdxD_i    (phtIdxD),
        .rs           (rsIf.source)
    );

    assign mispredict_o = rsIf.mispredict;

endmodule

// File: bench/tbTasks.svh
// Testbench helpers for the predicting front end
// Typed compare tasks, plain failure report and xorshift generator
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

task automatic failRun(input string reason);
    $display("%s", reason);
    $display("=== FAIL ===");
    $fatal(1, "run stopped");
endtask

task automatic checkXlen(input string what, input xlenT got, input xlenT exp);
    if (got !== exp) begin
        $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        $display("=== FAIL ===");
        $fatal(1, "value mismatch");
    end
endtask

task automatic checkBit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
        $display("** Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        $display("=== FAIL ===");
        $fatal(1, "value mismatch");
    end
endtask

// 32-bit xorshift step
function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

`endif

// File: bench/tbPredictorCore.sv
// Testbench for the predicting front end
// Instruction memory, cycle accurate reference model and directed tests
`timescale 1ns/1ps

module tbPredictorCore;
    import branchPkg::*;

    localparam int MaxCycles = 400;

    typedef struct packed {
        instrT instr;
        xlenT  pc;
        xlenT  srcA;
        xlenT  srcB;
        xlenT  imm;
        logic  pred;
        ghrT   idx;
    } stageT;

    logic  clk;
    logic  reset;
    instrT instrF_i;
    xlenT  srcAF_i;
    xlenT  srcBF_i;
    xlenT  pcF_o;
    logic  mispredict_o;

    // Program memory with per-word operands and the offset each word encodes
    instrT imem [64];
    xlenT  aMem [64];
    xlenT  bMem [64];
    xlenT  immMem [64];

    // Reference model state
    xlenT                  mPc;
    ghrT                   mGhr;
    counterT               mPht [2**GhrBits];
    logic [BtbEntries-1:0] mBtbV;
    logic [BtbTagBits-1:0] mBtbTag [BtbEntries];
    xlenT                  mBtbTgt [BtbEntries];
    stageT                 d;
    stageT                 e;

    int          pulseCount;
    int          cycleCount = 0;
    logic [31:0] rngState = 32'hd536e4ef;

    `include "tbTasks.svh"

    predictorCore u_dut (
        .clk          (clk),
        .reset        (reset),
        .instrF_i     (instrF_i),
        .srcAF_i      (srcAF_i),
        .srcBF_i      (srcBF_i),
        .pcF_o        (pcF_o),
        .mispredict_o (mispredict_o)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= MaxCycles) begin
            failRun("Timeout: the tests did not finish within the cycle limit");
        end
    end

    function automatic instrT encodeBranch(input funct3T f3, input xlenT off);
        return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], OpBranch};
    endfunction

    function automatic instrT encodeJal(input xlenT off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd1, OpJal};
    endfunction

    task automatic clearProgram();
        for (int i = 0; i < 64; i++) begin
            // addi x0, x0, index
            imem[i]   = {12'(i), 20'h00013};
            aMem[i]   = xlenT'(i * 4);
            bMem[i]   = ~xlenT'(i * 4);
            immMem[i] = '0;
        end
    endtask

    task automatic putBranch(input xlenT addr, input funct3T f3, input xlenT off,
                             input xlenT a, input xlenT b);
        imem[addr[7:2]]   = encodeBranch(f3, off);
        immMem[addr[7:2]] = off;
        aMem[addr[7:2]]   = a;
        bMem[addr[7:2]]   = b;
    endtask

    task automatic putJal(input xlenT addr, input xlenT off);
        imem[addr[7:2]]   = encodeJal(off);
        immMem[addr[7:2]] = off;
    endtask

    task automatic applyReset();
        reset = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        reset      = 1'b0;
        mPc        = ResetPc;
        mGhr       = '0;
        mBtbV      = '0;
        d          = '0;
        e          = '0;
        pulseCount = 0;
        for (int i = 0; i < 2**GhrBits; i++) begin
            mPht[i] = CounterInit;
        end
    endtask

    // Per cycle output check and reference model step
    task automatic runCycles(input int n);
        stageT f;
        logic  ctlE;
        logic  takenE;
        logic  mispE;
        int    fi;
        int    bi;
        for (int c = 0; c < n; c++) begin
            ctlE   = (e.instr[6:0] == OpBranch) || (e.instr[6:0] == OpJal);
            takenE = (e.instr[6:0] == OpJal) || ((e.instr[6:0] == OpBranch) &&
                     (((e.instr[14:12] == Funct3Beq) && (e.srcA == e.srcB)) ||
                      ((e.instr[14:12] == Funct3Bne) && (e.srcA != e.srcB))));
            mispE  = ctlE && (takenE != e.pred);
            if (mispredict_o) begin
                pulseCount++;
            end
            checkXlen("pcF_o", pcF_o, mPc);
            checkBit("mispredict_o", mispredict_o, mispE);

            fi       = pcF_o[7:2];
            instrF_i = imem[fi];
            srcAF_i  = aMem[fi];
            srcBF_i  = bMem[fi];

            // Fetch side prediction
            f.instr = imem[fi];
            f.pc    = mPc;
            f.srcA  = aMem[fi];
            f.srcB  = bMem[fi];
            f.imm   = immMem[fi];
            f.idx   = mPc[6:2] ^ mGhr;
            bi      = mPc[6:2];
            f.pred  = mBtbV[bi] && (mBtbTag[bi] == mPc[31:7]) &&
                      ((f.instr[6:0] == OpJal) ||
                       ((f.instr[6:0] == OpBranch) && (mPht[f.idx] >= 2'd2)));

            if (mispE) begin
                mGhr = '0;
                mPc  = e.pred ? (e.pc + 32'd4) : (e.pc + e.imm);
            end else begin
                if (f.instr[6:0] == OpBranch) begin
                    mGhr = {mGhr[GhrBits-2:0], mPht[f.idx] >= 2'd2};
                end
                mPc = f.pred ? mBtbTgt[bi] : (mPc + 32'd4);
            end

            // Execute side updates
            if ((e.instr[6:0] == OpBranch) && takenE && (mPht[e.idx] != 2'd3)) begin
                mPht[e.idx] = mPht[e.idx] + 2'd1;
            end else if ((e.instr[6:0] == OpBranch) && !takenE && (mPht[e.idx] != 2'd0)) begin
                mPht[e.idx] = mPht[e.idx] - 2'd1;
            end
            if (ctlE && takenE) begin
                mBtbV[e.pc[6:2]]   = 1'b1;
                mBtbTag[e.pc[6:2]] = e.pc[31:7];
                mBtbTgt[e.pc[6:2]] = e.pc + e.imm;
            end

            e = mispE ? stageT'('0) : d;
            d = mispE ? stageT'('0) : f;
            @(posedge clk);
            #1;
        end
    endtask

    task automatic noBranchTest();
        clearProgram();
        applyReset();
        checkXlen("pcF_o after reset", pcF_o, ResetPc);
        checkBit("mispredict_o after reset", mispredict_o, 1'b0);
        runCycles(12);
        checkXlen("pcF_o after straight line code", pcF_o, 32'd48);
    endtask

    task automatic coldBranchTest();
        clearProgram();
        putBranch(32'h10, Funct3Beq, 32'h20, 32'd5, 32'd5);
        // Both wrong path jals must be squashed
        putJal(32'h14, 32'h40);
        putJal(32'h18, 32'h40);
        putBranch(32'h30, Funct3Bne, 32'h10, 32'd7, 32'd7);
        applyReset();
        runCycles(6);
        checkBit("cold beq mispredict", mispredict_o, 1'b1);
        runCycles(1);
        checkXlen("pcF_o after beq redirect", pcF_o, 32'h30);
        runCycles(6);
        if (pulseCount != 1) begin
            failRun("Wrong-path jals or cold not-taken bne caused an extra mispredict");
        end
    endtask

    task automatic jalTest();
        clearProgram();
        putJal(32'h0C, 32'hFFFF_FFF4);
        applyReset();
        runCycles(5);
        checkBit("cold jal mispredict", mispredict_o, 1'b1);
        runCycles(1);
        checkXlen("pcF_o after jal redirect", pcF_o, 32'h0);
        runCycles(3);
        checkXlen("pcF_o at second jal fetch", pcF_o, 32'h0C);
        runCycles(1);
        checkXlen("pcF_o after predicted jal", pcF_o, 32'h0);
        runCycles(8);
        if (pulseCount != 1) begin
            failRun("Jal still mispredicted after its BTB entry was written");
        end
    endtask

    task automatic loopTrainTest();
        int waitCount;
        clearProgram();
        putBranch(32'h0C, Funct3Beq, 32'hFFFF_FFF4, 32'd9, 32'd9);
        applyReset();
        runCycles(128);
        pulseCount = 0;
        runCycles(16);
        if (pulseCount != 0) begin
            failRun("Trained loop branch still mispredicts");
        end
        // Loop exit
        bMem[3]   = 32'd10;
        waitCount = 0;
        while (!mispredict_o && (waitCount < 8)) begin
            runCycles(1);
            waitCount++;
        end
        if (!mispredict_o) begin
            failRun("No mispredict after the loop branch turned not taken");
        end
        runCycles(1);
        checkXlen("pcF_o after loop exit", pcF_o, 32'h10);
    endtask

    task automatic randomStreamTest();
        clearProgram();
        for (int k = 0; k < 6; k++) begin
            putBranch(xlenT'(8 * k + 4), (k % 2 == 1) ? Funct3Bne : Funct3Beq,
                      32'd8, 32'd0, 32'd0);
        end
        putJal(32'h34, 32'hFFFF_FFCC);
        applyReset();
        repeat (10) begin
            for (int k = 0; k < 6; k++) begin
                // Small operand range so both outcomes occur
                rngState         = xorshift32(rngState);
                aMem[2 * k + 1]  = xlenT'(rngState[1:0]);
                bMem[2 * k + 1]  = xlenT'(rngState[3:2]);
            end
            runCycles(10);
        end
    endtask

    initial begin
        reset    = 1'b1;
        instrF_i = '0;
        srcAF_i  = '0;
        srcBF_i  = '0;
        noBranchTest();
        coldBranchTest();
        jalTest();
        loopTrainTest();
        randomStreamTest();
        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: build.f
+incdir+bench
hw/branchPkg.sv
hw/branchIfs.sv
hw/branchTargetBuffer.sv
hw/gsharePredictor.sv
hw/fetchUnit.sv
hw/decodeStage.sv
hw/branchResolver.sv
hw/predictorCore.sv
bench/tbPredictorCore.sv
